//--- hdl/fpls_pkg.sv
package fpls_pkg;

  // --------------------
  // sizing
  // --------------------
  localparam int ADDR_W      = 6;    // word address, 64 words
  localparam int WORD_W      = 128;  // memory word
  localparam int TAG_W       = 4;    // load tag
  localparam int REQ_DEPTH   = 4;    // request fifo depth, also sender credits
  localparam int RSP_CREDITS = 2;    // response credits granted at reset

  // exponent handling
  localparam logic [15:0] EXP_REBIAS = 16'h4000;  // native = extended + rebias
  localparam logic [15:0] EXP_OVFL   = 16'hbffe;  // largest finite native exp on store

  // --------------------
  // number formats
  // --------------------

  // internal 81-bit format
  typedef struct packed {
    logic        sign;
    logic [15:0] exp;
    logic [63:0] mant;   // explicit integer bit
  } native_t;

  // 80-bit extended format as held in memory
  typedef struct packed {
    logic        sign;
    logic [14:0] exp;
    logic [63:0] mant;
  } ext_t;

  // --------------------
  // channel payloads
  // --------------------
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
  } ld_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    native_t           value;
  } st_req_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    native_t          value;
  } ld_rsp_t;

  // word ram request, shared by both masters
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
  } mem_req_t;

endpackage

//--- hdl/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,       // sender spends one credit
  input  payload_t din,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     credit      // one credit back per pop
);

  localparam int              PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

  payload_t         buf_q [DEPTH];  // storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_pop;

  assign do_pop    = pop & not_empty;     // ignore pop on empty
  assign not_empty = (count != '0);
  assign head      = buf_q[rd_ptr];       // head visible the cycle after push

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk) begin
    if (push) buf_q[wr_ptr] <= din;
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(do_pop);
    end
  end

  // credit return, registered one cycle behind the pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) credit <= 1'b0;
    else        credit <= do_pop;
  end

  // a push into a full buffer means the sender overspent its credits
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < FULL_CNT))
    else $error("credit_fifo: push while full");

endmodule

//--- hdl/ext_load_path.sv
`timescale 1ns/1ps

module ext_load_path (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_pending,   // fifo not empty
  input  fpls_pkg::ld_req_t           req_head,
  output logic                        pop,
  output fpls_pkg::mem_req_t          mem_req,
  output logic                        mem_req_valid,
  input  logic                        gnt,
  input  logic [fpls_pkg::WORD_W-1:0] rdata,
  input  logic                        rsp_credit,    // consumer returns one credit
  output logic                        ld_rsp_valid,
  output fpls_pkg::ld_rsp_t           ld_rsp
);
  import fpls_pkg::*;

  localparam int CNT_W = $clog2(RSP_CREDITS + 1);

  logic [CNT_W-1:0] rsp_cr;     // response credits held
  logic [CNT_W-1:0] inflight;   // reads granted, response not yet presented
  logic             s1_valid;   // read data on rdata this cycle
  logic [TAG_W-1:0] s1_tag;
  ext_t             ext_in;
  native_t          nat_cvt;

  // --------------------
  // request side
  // --------------------
  assign mem_req_valid = req_pending && (inflight < rsp_cr);  // never outrun credits
  assign pop           = gnt;                                  // fifo pops on grant

  always_comb begin
    mem_req       = '0;
    mem_req.we    = 1'b0;           // read
    mem_req.addr  = req_head.addr;
  end

  // credit and outstanding counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_cr   <= CNT_W'(RSP_CREDITS);
      inflight <= '0;
    end else begin
      rsp_cr   <= rsp_cr + CNT_W'(rsp_credit) - CNT_W'(ld_rsp_valid);
      inflight <= inflight + CNT_W'(gnt) - CNT_W'(ld_rsp_valid);
    end
  end

  // --------------------
  // extended to native
  // --------------------
  assign ext_in = rdata[79:0];   // upper word bits carry nothing

  always_comb begin
    nat_cvt = '0;                               // zero and denormals flush, sign dropped
    if (ext_in.exp == 15'h7fff) begin           // inf / nan keep sign and mantissa
      nat_cvt.sign = ext_in.sign;
      nat_cvt.exp  = 16'hffff;
      nat_cvt.mant = ext_in.mant;
    end else if (ext_in.exp != '0) begin
      nat_cvt.sign = ext_in.sign;
      nat_cvt.exp  = {1'b0, ext_in.exp} + EXP_REBIAS;  // rebias
      nat_cvt.mant = ext_in.mant;
    end
  end

  // --------------------
  // tag pipeline
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid     <= 1'b0;
      ld_rsp_valid <= 1'b0;
    end else begin
      s1_valid     <= gnt;        // ram read issued this cycle
      ld_rsp_valid <= s1_valid;   // response two cycles after grant
    end
  end

  always_ff @(posedge clk) begin
    if (gnt) s1_tag <= req_head.tag;
    if (s1_valid) begin
      ld_rsp.tag   <= s1_tag;
      ld_rsp.value <= nat_cvt;
    end
  end

  // response presented only against a held credit
  a_rsp_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    ld_rsp_valid |-> (rsp_cr != '0))
    else $error("ext_load_path: response without credit");

endmodule

//--- hdl/ext_store_path.sv
`timescale 1ns/1ps

module ext_store_path (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_pending,
  input  fpls_pkg::st_req_t  req_head,
  output logic               pop,
  output fpls_pkg::mem_req_t mem_req,
  output logic               mem_req_valid,
  input  logic               gnt,
  output logic               st_ack        // write done, one cycle after grant
);
  import fpls_pkg::*;

  native_t     nat;
  ext_t        ext_out;
  logic [15:0] exp_sub;    // rebiased exponent
  logic        underflow;  // at or below the bias, flushes to zero
  logic        overflow;   // too large for a finite extended value
  logic        unordered;  // inf / nan class

  assign nat = req_head.value;

  // --------------------
  // classification
  // --------------------
  assign unordered = &nat.exp;
  assign underflow = (nat.exp <= EXP_REBIAS);
  assign overflow  = (nat.exp > EXP_OVFL) && !unordered;
  assign exp_sub   = nat.exp - EXP_REBIAS;   // in range only for finite values

  // native to extended
  always_comb begin
    ext_out = '0;                            // underflow gives all zero
    if (unordered) begin
      ext_out.sign = nat.sign;
      ext_out.exp  = 15'h7fff;
      ext_out.mant = nat.mant;               // payload kept
    end else if (overflow) begin
      ext_out.sign = nat.sign;
      ext_out.exp  = 15'h7fff;               // infinity, mantissa zero
    end else if (!underflow) begin
      ext_out.sign = nat.sign;
      ext_out.exp  = exp_sub[14:0];
      ext_out.mant = nat.mant;
    end
  end

  // --------------------
  // memory write
  // --------------------
  assign mem_req_valid = req_pending;
  assign pop           = gnt;          // write lands in the grant cycle

  always_comb begin
    mem_req       = '0;
    mem_req.we    = 1'b1;
    mem_req.addr  = req_head.addr;
    mem_req.wdata = WORD_W'(ext_out);  // upper 48 bits zero
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) st_ack <= 1'b0;
    else        st_ack <= gnt;
  end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  fpls_pkg::mem_req_t ld_req,
  input  logic               ld_valid,
  input  fpls_pkg::mem_req_t st_req,
  input  logic               st_valid,
  output logic               ld_gnt,
  output logic               st_gnt,
  output fpls_pkg::mem_req_t ram_req,
  output logic               ram_en
);

  logic last_st;   // store won the last granted cycle

  // --------------------
  // round robin
  // --------------------
  // on contention the master that lost last time wins
  assign ld_gnt = ld_valid && (!st_valid || last_st);
  assign st_gnt = st_valid && (!ld_valid || !last_st);

  assign ram_en  = ld_gnt | st_gnt;
  assign ram_req = st_gnt ? st_req : ld_req;   // winner's request to the ram

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_st <= 1'b0;           // store has priority on first contention
    end else if (ld_gnt) begin
      last_st <= 1'b0;
    end else if (st_gnt) begin
      last_st <= 1'b1;
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(ld_gnt && st_gnt))
    else $error("mem_arbiter: both masters granted");

  // sustained contention alternates, load cannot starve the store
  a_alternate: assert property (@(posedge clk) disable iff (!rst_n)
    (ld_valid && st_valid && ld_gnt) ##1 (ld_valid && st_valid) |-> st_gnt)
    else $error("mem_arbiter: grant did not alternate");

endmodule

//--- hdl/fp_word_ram.sv
`timescale 1ns/1ps

module fp_word_ram (
  input  logic                        clk,
  input  fpls_pkg::mem_req_t          req,
  input  logic                        en,
  output logic [fpls_pkg::WORD_W-1:0] rdata   // valid the cycle after the read
);
  import fpls_pkg::*;

  localparam int WORDS = 1 << ADDR_W;   // 64

  logic [WORD_W-1:0] mem [WORDS];

  // --------------------
  // single port access
  // --------------------
  always_ff @(posedge clk) begin
    if (en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;   // write, no read data
      end else begin
        rdata <= mem[req.addr];       // registered read
      end
    end
  end

endmodule

//--- hdl/fp_mem_unit.sv
`timescale 1ns/1ps

module fp_mem_unit (
  input  logic              clk,
  input  logic              rst_n,
  // load requests
  input  logic              ld_req_valid,
  input  fpls_pkg::ld_req_t ld_req,
  output logic              ld_req_credit,
  // store requests
  input  logic              st_req_valid,
  input  fpls_pkg::st_req_t st_req,
  output logic              st_req_credit,
  // load responses
  output logic              ld_rsp_valid,
  output fpls_pkg::ld_rsp_t ld_rsp,
  input  logic              ld_rsp_credit,
  output logic              st_ack
);
  import fpls_pkg::*;

  // --------------------
  // request queues
  // --------------------
  ld_req_t           ld_head;
  logic              ld_not_empty;
  logic              ld_pop;
  st_req_t           st_head;
  logic              st_not_empty;
  logic              st_pop;

  // memory bus
  mem_req_t          ld_mem_req;
  mem_req_t          st_mem_req;
  mem_req_t          ram_req;
  logic              ld_mem_valid;
  logic              st_mem_valid;
  logic              ld_gnt;
  logic              st_gnt;
  logic              ram_en;
  logic [WORD_W-1:0] ram_rdata;

  credit_fifo #(.payload_t(ld_req_t), .DEPTH(REQ_DEPTH)) u_ld_fifo (
    .clk, .rst_n, .push(ld_req_valid), .din(ld_req), .pop(ld_pop),
    .head(ld_head), .not_empty(ld_not_empty), .credit(ld_req_credit)
  );

  credit_fifo #(.payload_t(st_req_t), .DEPTH(REQ_DEPTH)) u_st_fifo (
    .clk, .rst_n, .push(st_req_valid), .din(st_req), .pop(st_pop),
    .head(st_head), .not_empty(st_not_empty), .credit(st_req_credit)
  );

  // --------------------
  // masters
  // --------------------
  ext_load_path u_load (
    .clk, .rst_n, .req_pending(ld_not_empty), .req_head(ld_head), .pop(ld_pop),
    .mem_req(ld_mem_req), .mem_req_valid(ld_mem_valid), .gnt(ld_gnt),
    .rdata(ram_rdata), .rsp_credit(ld_rsp_credit), .ld_rsp_valid, .ld_rsp
  );

  ext_store_path u_store (
    .clk, .rst_n, .req_pending(st_not_empty), .req_head(st_head), .pop(st_pop),
    .mem_req(st_mem_req), .mem_req_valid(st_mem_valid), .gnt(st_gnt), .st_ack
  );

  // shared word ram
  mem_arbiter u_arb (
    .clk, .rst_n, .ld_req(ld_mem_req), .ld_valid(ld_mem_valid),
    .st_req(st_mem_req), .st_valid(st_mem_valid), .ld_gnt, .st_gnt,
    .ram_req, .ram_en
  );

  fp_word_ram u_ram (
    .clk, .req(ram_req), .en(ram_en), .rdata(ram_rdata)
  );

endmodule

//--- testbench/tb_fp_mem_unit.sv
`timescale 1ns/1ps

module tb_fp_mem_unit;
  import fpls_pkg::*;

  localparam int N_OPS    = 60;          // loads plus stores over all tests
  localparam int WD_LIMIT = N_OPS * 40;  // watchdog budget in cycles

  logic    clk;
  logic    rst_n;
  logic    ld_req_valid;
  ld_req_t ld_req;
  logic    ld_req_credit;
  logic    st_req_valid;
  st_req_t st_req;
  logic    st_req_credit;
  logic    ld_rsp_valid;
  ld_rsp_t ld_rsp;
  logic    ld_rsp_credit;
  logic    st_ack;

  integer  seed;
  native_t exp_val   [16];   // expected response per tag
  logic    tag_busy  [16];   // load outstanding on this tag
  ext_t    mem_model [64];   // extended words as stored
  logic [3:0] next_tag = 4'd0;

  // credit and progress counters
  int    ld_credits = REQ_DEPTH;
  int    st_credits = REQ_DEPTH;
  int    rsp_held   = RSP_CREDITS;   // response credits the DUT holds
  int    owed       = 0;             // response credits not yet returned
  int    ld_issued  = 0;
  int    st_issued  = 0;
  int    ld_rsps    = 0;
  int    st_acks    = 0;
  logic  withhold   = 1'b0;          // keep response credits back
  int    wh_rsp     = 0;
  int    wh_credit  = 0;
  string test_name  = "reset";
  int    err_count  = 0;
  int    tests_run  = 0;
  int    tests_failed = 0;
  int    err_start;
  int    ld_start;
  int    st_start;

  fp_mem_unit UUT (
    .clk, .rst_n, .ld_req_valid, .ld_req, .ld_req_credit,
    .st_req_valid, .st_req, .st_req_credit,
    .ld_rsp_valid, .ld_rsp, .ld_rsp_credit, .st_ack
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic ext_t to_ext(input native_t v);
    ext_t e;
    e = '0;                                      // underflow stores as zero
    if (v.exp == 16'hffff) begin
      e = {v.sign, 15'h7fff, v.mant};
    end else if (v.exp > EXP_OVFL) begin
      e = {v.sign, 15'h7fff, 64'h0};             // infinity
    end else if (v.exp > EXP_REBIAS) begin
      e = {v.sign, 15'(v.exp - EXP_REBIAS), v.mant};
    end
    return e;
  endfunction

  function automatic native_t to_native(input ext_t e);
    if (e.exp == 15'h0) return '0;               // denormal flushed, sign lost
    if (e.exp == 15'h7fff) return {e.sign, 16'hffff, e.mant};
    return {e.sign, {1'b0, e.exp} + EXP_REBIAS, e.mant};
  endfunction

  function automatic logic [15:0] rand_exp(input logic [15:0] lo, input logic [15:0] hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + 16'(r % ({16'h0, hi} - {16'h0, lo} + 32'd1));
  endfunction

  // kind 0 normal, 1 underflow, 2 overflow, 3 unordered; edges first
  function automatic native_t make_value(input int kind, input int i);
    native_t v;
    v.sign = i[0];
    v.mant = {$random(seed), $random(seed)};
    case (kind)
      0:       v.exp = rand_exp(16'h4001, EXP_OVFL);
      1:       v.exp = (i == 0) ? EXP_REBIAS : rand_exp(16'h0000, EXP_REBIAS);
      2:       v.exp = (i == 0) ? 16'hbfff : (i == 1) ? 16'hfffe : rand_exp(16'hbfff, 16'hfffe);
      default: v.exp = 16'hffff;
    endcase
    return v;
  endfunction

  // --------------------
  // stimulus helpers
  // --------------------
  task automatic step_cycle;
    @(posedge clk);
    #1;                                          // drive just after the edge
  endtask

  task automatic issue_load(input logic [5:0] addr);
    ld_req_valid = 1'b1;
    ld_req.tag   = next_tag;
    ld_req.addr  = addr;
    exp_val[next_tag]  = to_native(mem_model[addr]);
    tag_busy[next_tag] = 1'b1;
    next_tag = next_tag + 4'd1;
    ld_credits--;
    ld_issued++;
  endtask

  task automatic issue_store(input logic [5:0] addr, input native_t v);
    st_req_valid  = 1'b1;
    st_req.addr   = addr;
    st_req.value  = v;
    mem_model[addr] = to_ext(v);
    st_credits--;
    st_issued++;
  endtask

  task automatic push_load(input logic [5:0] addr);
    while (ld_credits == 0) step_cycle();       // spend only held credits
    issue_load(addr);
    step_cycle();
    ld_req_valid = 1'b0;
  endtask

  task automatic push_store(input logic [5:0] addr, input native_t v);
    while (st_credits == 0) step_cycle();
    issue_store(addr, v);
    step_cycle();
    st_req_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = err_count;
    ld_start  = ld_issued;
    st_start  = st_issued;
  endtask

  task automatic finish_test;
    while (st_acks != st_issued || ld_rsps != ld_issued) step_cycle();
    repeat (2) step_cycle();                    // trailing credits come home
    tests_run++;
    if (err_count != err_start) tests_failed++;
    $display("%s done: loads %0d stores %0d errors %0d", test_name,
             ld_issued - ld_start, st_issued - st_start, err_count - err_start);
  endtask

  // store a class of values, wait for the acks, then read them back
  task automatic run_class(input string name, input int kind, input int base, input int n);
    start_test(name);
    for (int i = 0; i < n; i++) push_store(6'(base + i), make_value(kind, i));
    while (st_acks != st_issued) step_cycle();
    for (int i = 0; i < n; i++) push_load(6'(base + i));
    finish_test();
  endtask

  task automatic run_mixed(input int n);
    native_t    v;
    logic [5:0] ld_addr;
    start_test("mixed");
    for (int i = 0; i < n; i++) begin
      v       = make_value(0, i);
      ld_addr = 6'($unsigned($random(seed)) % 20);   // words 0..19 already hold data
      while (ld_credits == 0 || st_credits == 0) step_cycle();
      issue_load(ld_addr);
      issue_store(6'(32 + i), v);   // stores go to other words
      step_cycle();
      ld_req_valid = 1'b0;
      st_req_valid = 1'b0;
    end
    finish_test();
  endtask

  task automatic run_backpress;
    start_test("backpress");
    withhold  = 1'b1;
    wh_rsp    = 0;
    wh_credit = 0;
    for (int i = 0; i < REQ_DEPTH; i++) push_load(6'(i));
    repeat (20) step_cycle();
    assert (wh_rsp == RSP_CREDITS) else begin
      err_count++;
      $display("ERR %s responses under held credits expected %0d actual %0d",
               test_name, RSP_CREDITS, wh_rsp);
    end
    withhold = 1'b0;
    finish_test();
  endtask

  // --------------------
  // response side monitor
  // --------------------
  initial begin
    logic give;
    ld_rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      give = 1'b0;
      if (rst_n) begin
        if (ld_rsp_valid) begin
          tag_busy[ld_rsp.tag] = 1'b0;
          ld_rsps++;
          rsp_held--;
          owed++;
          if (withhold) wh_rsp++;
        end
        if (ld_rsp_credit) rsp_held++;
        if (ld_req_credit) begin
          ld_credits++;
          if (withhold) wh_credit++;
        end
        if (st_req_credit) st_credits++;
        if (st_ack) st_acks++;
        give = !withhold && (owed > 0);   // one credit back per cycle
        if (give) owed--;
      end
      #1;
      ld_rsp_credit = give;
    end
  end

  // --------------------
  // checks
  // --------------------
  a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
    ld_rsp_valid |-> (ld_rsp.value == exp_val[ld_rsp.tag]))
    else begin
      err_count++;
      $display("ERR %s tag %0d expected %h actual %h", test_name, $sampled(ld_rsp.tag),
               exp_val[$sampled(ld_rsp.tag)], $sampled(ld_rsp.value));
    end

  a_rsp_tag: assert property (@(posedge clk) disable iff (!rst_n)
    ld_rsp_valid |-> tag_busy[ld_rsp.tag])
    else begin
      err_count++;
      $display("%s: response carries a tag with no load outstanding", test_name);
    end

  a_rsp_credit: assert property (@(posedge clk) disable iff (!rst_n)
    ld_rsp_valid |-> (rsp_held > 0))
    else begin
      err_count++;
      $display("%s: response presented without a response credit", test_name);
    end

  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (ld_credits <= REQ_DEPTH) && (st_credits <= REQ_DEPTH))
    else begin
      err_count++;
      $display("%s: a credit count rose above its initial value", test_name);
    end

  a_ack: assert property (@(posedge clk) disable iff (!rst_n)
    st_ack |-> (st_acks < st_issued))
    else begin
      err_count++;
      $display("%s: store acknowledge with no store outstanding", test_name);
    end

  a_hold_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    withhold |-> (wh_rsp <= RSP_CREDITS))
    else begin
      err_count++;
      $display("%s: more responses than response credits", test_name);
    end

  a_hold_credit: assert property (@(posedge clk) disable iff (!rst_n)
    withhold |-> (wh_credit <= RSP_CREDITS))
    else begin
      err_count++;
      $display("%s: load request credits kept returning under back-pressure", test_name);
    end

  // watchdog
  initial begin
    repeat (WD_LIMIT + 10) @(posedge clk);
    $display("watchdog expired, test %s did not finish", test_name);
    $display("Testbench failed");
    $finish;
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    seed         = 32'h9b5d;
    rst_n        = 1'b0;
    ld_req_valid = 1'b0;
    ld_req       = '0;
    st_req_valid = 1'b0;
    st_req       = '0;
    for (int t = 0; t < 16; t++) tag_busy[t] = 1'b0;
    for (int a = 0; a < 64; a++) mem_model[a] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step_cycle();
    run_class("roundtrip", 0, 0, 8);
    run_class("underflow", 1, 8, 4);
    run_class("overflow", 2, 12, 4);
    run_class("unordered", 3, 16, 4);
    run_mixed(8);
    run_backpress();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- fp_mem_unit.f
hdl/fpls_pkg.sv
hdl/credit_fifo.sv
hdl/ext_load_path.sv
hdl/ext_store_path.sv
hdl/mem_arbiter.sv
hdl/fp_word_ram.sv
hdl/fp_mem_unit.sv
testbench/tb_fp_mem_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fp_mem_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_fp_mem_unit \
  -f fp_mem_unit.f \
  -o sim_fp_mem_unit

# the log decides the result, a crashed run leaves no pass line
./obj_dir/sim_fp_mem_unit | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi
